// ==== list.f ====
+incdir+design
design/rv_pipe_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/operand_stage.sv
design/execute_stage.sv
design/rv_pipe_top.sv
bench/rv_pipe_assertions.sv
bench/rv_pipe_checker.sv
bench/rv_pipe_tb.sv

// ==== Makefile ====
TOP = rv_pipe_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== bench/rv_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_consts.svh"

module rv_pipe_tb;

    logic                 clock;
    logic                 arst_n;
    logic                 inst_valid;
    logic [31:0]          inst;
    logic [63:0]          pc;
    logic                 retire_valid;
    rv_pipe_pkg::retire_t retire;
    int                   errors;
    int                   checked;
    int                   pending;
    int                   issued;
    int                   timeouts;
    int                   wait_cycles;
    logic [63:0]          next_pc;

    rv_pipe_top dut_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    rv_pipe_checker checker_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire),
        .errors       (errors),
        .checked      (checked),
        .pending      (pending)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // Few registers so that dependencies are frequent
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(0, 5));
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  f3w;
        logic [31:0] r;
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        r   = $urandom;
        f3  = r[14:12];
        f3w = r[13] ? `F3_SRL : (r[12] ? `F3_SLL : `F3_ADD);   // Word ops only
        case ($urandom_range(0, 9))
            0: return {r[31:12], rd, `OPC_LUI};
            1: return {r[31:12], rd, `OPC_AUIPC};
            2: return {r[31:12], rd, `OPC_JAL};
            3: return {r[31:20], rs1, 3'b000, rd, `OPC_JALR};
            4: return {r[31:25], rs2, rs1, f3, r[11:7], `OPC_BRANCH};
            5: begin
                if (f3[1:0] == 2'b01)
                    return {1'b0, r[30] & f3[2], 4'b0000, r[25:20], rs1, f3, rd, `OPC_OP_IMM};
                return {r[31:20], rs1, f3, rd, `OPC_OP_IMM};
            end
            6: return {1'b0, r[30] & (f3 == `F3_ADD || f3 == `F3_SRL), 5'b00000, rs2, rs1, f3,
                       rd, `OPC_OP};
            7: begin
                if (f3w == `F3_ADD)
                    return {r[31:20], rs1, f3w, rd, `OPC_OP_IMM_32};
                return {1'b0, r[30] & f3w[2], 5'b00000, r[24:20], rs1, f3w, rd, `OPC_OP_IMM_32};
            end
            8: return {1'b0, r[30] & (f3w != `F3_SLL), 5'b00000, rs2, rs1, f3w, rd, `OPC_OP_32};
            default: begin
                case (r[1:0])
                    2'd0:    return {r[31:12], rd, 7'b0000011};   // Load
                    2'd1:    return {r[31:12], rd, 7'b1110011};   // System
                    2'd2:    return {`F7_MEXT, rs2, rs1, f3, rd, `OPC_OP};
                    default: return {`F7_BASE, rs2, rs1, `F3_SLT, rd, `OPC_OP_32};
                endcase
            end
        endcase
    endfunction

    initial begin
        void'($urandom(32'hae430ad9));
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        issued     = 0;
        timeouts   = 0;
        next_pc    = 64'h0000_0000_8000_0000;
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;

        repeat (600) begin
            @(posedge clock);
            inst_valid <= 1'b1;
            inst       <= random_inst();
            pc         <= next_pc;
            issued++;
            if ($urandom_range(0, 7) == 0)
                next_pc = {$urandom, $urandom} & ~64'd3;   // Taken jump somewhere
            else
                next_pc = next_pc + 64'd4;
            if ($urandom_range(0, 3) == 0) begin
                @(posedge clock);
                inst_valid <= 1'b0;
                repeat ($urandom_range(0, 3)) @(posedge clock);
            end
        end
        @(posedge clock);
        inst_valid <= 1'b0;

        wait_cycles = 0;
        while (checked != issued && wait_cycles < 20) begin
            @(negedge clock);
            wait_cycles++;
        end
        if (checked != issued) begin
            $display("Timeout: only %0d of %0d instructions retired", checked, issued);
            timeouts++;
        end

        $display("Summary: %0d issued, %0d checked, %0d errors, %0d timeouts",
                 issued, checked, errors, timeouts);
        if (errors == 0 && timeouts == 0 && pending == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/rv_pipe_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_consts.svh"

module rv_pipe_checker (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 inst_valid,
    input  logic [31:0]          inst,
    input  logic [63:0]          pc,
    input  logic                 retire_valid,
    input  rv_pipe_pkg::retire_t retire,
    output int                   errors,
    output int                   checked,
    output int                   pending
);

    localparam int KIND_PLAIN   = 0;
    localparam int KIND_JUMP    = 1;
    localparam int KIND_BRANCH  = 2;
    localparam int KIND_ILLEGAL = 3;

    logic [63:0]          regs [0:31];   // Architectural model, x0 never written
    rv_pipe_pkg::retire_t exp_q [$];
    int                   kind_q [$];
    int                   cycle_q [$];
    int                   cycle;

    task automatic check_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h got %h at pc %h", name, expected, actual, retire.pc);
            errors++;
        end
    endtask

    function automatic logic op_legal(input logic reg_form, input logic word,
                                      input logic [2:0] f3, input logic [6:0] f7);
        logic [6:0] hi;
        hi = (reg_form || word) ? f7 : {f7[6:1], 1'b0};   // RV64 shamt[5] sits in bit 25
        if (word && !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
            return 1'b0;
        if (!reg_form && f3 != 3'd1 && f3 != 3'd5)
            return 1'b1;
        if (f3 == 3'd0 || f3 == 3'd5)
            return hi == 7'h00 || hi == 7'h20;
        return hi == 7'h00;
    endfunction

    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic word, input logic [63:0] a,
                                            input logic [63:0] b);
        logic [5:0]  sh;
        logic [31:0] lo;
        logic [63:0] res;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        lo = a[31:0];
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = {63'd0, $signed(a) < $signed(b)};
            3'd3: res = {63'd0, a < b};
            3'd4: res = a ^ b;
            3'd6: res = a | b;
            3'd7: res = a & b;
            default: begin   // Right shifts
                if (word && alt)
                    lo = $signed(lo) >>> sh;
                else if (word)
                    lo = lo >> sh;
                if (word)
                    res = {32'd0, lo};
                else if (alt)
                    res = $signed(a) >>> sh;
                else
                    res = a >> sh;
            end
        endcase
        if (word)
            res = {{32{res[31]}}, res[31:0]};
        return res;
    endfunction

    function automatic rv_pipe_pkg::retire_t predict(input logic [31:0] w,
                                                     input logic [63:0] at_pc, output int kind);
        rv_pipe_pkg::retire_t r;
        logic [6:0]           opc;
        logic [2:0]           f3;
        logic [63:0]          a;
        logic [63:0]          b;
        logic [63:0]          i_imm;
        logic [63:0]          u_imm;
        logic                 reg_form;
        logic                 word;
        logic                 ok;
        opc      = w[6:0];
        f3       = w[14:12];
        a        = regs[w[19:15]];
        b        = regs[w[24:20]];
        i_imm    = {{52{w[31]}}, w[31:20]};
        u_imm    = {{32{w[31]}}, w[31:12], 12'b0};
        reg_form = opc == `OPC_OP || opc == `OPC_OP_32;
        word     = opc == `OPC_OP_IMM_32 || opc == `OPC_OP_32;
        r        = '0;
        r.pc     = at_pc;
        r.rd     = w[11:7];
        kind     = KIND_PLAIN;
        ok       = 1'b1;
        case (opc)
            `OPC_LUI:   r.value = u_imm;
            `OPC_AUIPC: r.value = at_pc + u_imm;
            `OPC_JAL, `OPC_JALR: begin
                kind    = KIND_JUMP;
                ok      = opc == `OPC_JAL || f3 == 3'd0;
                r.value = at_pc + 64'd4;
                r.taken = 1'b1;
                if (opc == `OPC_JAL)
                    r.target = at_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                else
                    r.target = (a + i_imm) & ~64'd1;
            end
            `OPC_BRANCH: begin
                kind     = KIND_BRANCH;
                r.rd     = 5'd0;
                r.target = at_pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'd0:    r.taken = a == b;
                    3'd1:    r.taken = a != b;
                    3'd4:    r.taken = $signed(a) < $signed(b);
                    3'd5:    r.taken = $signed(a) >= $signed(b);
                    3'd6:    r.taken = a < b;
                    3'd7:    r.taken = a >= b;
                    default: ok = 1'b0;
                endcase
            end
            `OPC_OP_IMM, `OPC_OP, `OPC_OP_IMM_32, `OPC_OP_32: begin
                ok      = op_legal(reg_form, word, f3, w[31:25]);
                r.value = alu_ref(f3, w[30] && (reg_form || f3 == 3'd5), word, a,
                                  reg_form ? b : i_imm);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            kind      = KIND_ILLEGAL;
            r.rd      = 5'd0;
            r.illegal = 1'b1;
        end
        return r;
    endfunction

    always @(posedge clock) begin
        rv_pipe_pkg::retire_t exp;
        rv_pipe_pkg::retire_t pred;
        int                   kind;
        cycle++;
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] = '0;
        end
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("Retire at pc %h arrived with no instruction outstanding", retire.pc);
                errors++;
            end else begin
                exp  = exp_q.pop_front();
                kind = kind_q.pop_front();
                check_field("latency", 64'd3, 64'(cycle - cycle_q.pop_front()));
                check_field("pc", exp.pc, retire.pc);
                check_field("illegal", 64'(exp.illegal), 64'(retire.illegal));
                if (kind != KIND_ILLEGAL) begin
                    check_field("rd", 64'(exp.rd), 64'(retire.rd));
                    check_field("taken", 64'(exp.taken), 64'(retire.taken));
                end
                if (kind == KIND_PLAIN || kind == KIND_JUMP)
                    check_field("value", exp.value, retire.value);
                if (kind == KIND_JUMP || kind == KIND_BRANCH)
                    check_field("target", exp.target, retire.target);
                checked++;
            end
        end
        if (arst_n && inst_valid) begin
            pred = predict(inst, pc, kind);
            if (kind != KIND_ILLEGAL && kind != KIND_BRANCH && pred.rd != 5'd0)
                regs[pred.rd] = pred.value;   // Sequential semantics
            exp_q.push_back(pred);
            kind_q.push_back(kind);
            cycle_q.push_back(cycle);
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== bench/rv_pipe_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_assertions (
    input logic             clock,
    input logic             arst_n,
    input logic             inst_valid,
    input logic             decoded_valid,
    input logic [4:0]       decoded_rs2,
    input logic             operand_valid,
    input logic [63:0]      operand_rs2,
    input logic             retire_valid,
    input rv_pipe_pkg::wb_t wb
);

    // Decode, operand and retire registers between strobe and retire pulse
    retire_latency: assert property (@(posedge clock) disable iff (!arst_n)
        retire_valid == $past(inst_valid, 3))
        else $error("retire_valid does not follow inst_valid by three cycles");

    // x0 is never written, so reading it through the register file and bypass gives zero
    x0_reads_zero: assert property (@(posedge clock) disable iff (!arst_n)
        decoded_valid && decoded_rs2 == 5'd0 |=> operand_rs2 == 64'd0)
        else $error("x0 read as a nonzero value in the operand stage");

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> !decoded_valid && !operand_valid && !retire_valid && !wb.enable)
        else $error("a stage is valid while reset is asserted");

endmodule

bind rv_pipe_top rv_pipe_assertions assertions_i (
    .clock         (clock),
    .arst_n        (arst_n),
    .inst_valid    (inst_valid),
    .decoded_valid (decoded.valid),
    .decoded_rs2   (decoded.rs2),
    .operand_valid (operands.valid),
    .operand_rs2   (operands.rs2_value),
    .retire_valid  (retire_valid),
    .wb            (wb)
);

`default_nettype wire

// ==== design/rv_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 inst_valid,
    input  logic [31:0]          inst,
    input  logic [63:0]          pc,
    output logic                 retire_valid,
    output rv_pipe_pkg::retire_t retire
);

    rv_pipe_pkg::decoded_t decoded;
    rv_pipe_pkg::operand_t operands;
    rv_pipe_pkg::wb_t      wb;   // Feeds the register file and the bypass

    inst_decoder decoder_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .decoded    (decoded)
    );

    operand_stage operand_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .decoded  (decoded),
        .wb       (wb),
        .operands (operands)
    );

    execute_stage execute_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .operands     (operands),
        .wb           (wb),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_consts.svh"

module execute_stage (
    input  logic                  clock,
    input  logic                  arst_n,
    input  rv_pipe_pkg::operand_t operands,
    output rv_pipe_pkg::wb_t      wb,
    output logic                  retire_valid,
    output rv_pipe_pkg::retire_t  retire
);

    logic [5:0]          shamt;
    logic [31:0]         a_lo;
    logic [31:0]         sra_w;
    logic [`RV_XLEN-1:0] sra_d;
    logic [`RV_XLEN-1:0] alu_raw;
    logic [`RV_XLEN-1:0] alu_res;
    logic                eq;
    logic                lt;
    logic                ltu;
    logic                cond;
    logic                taken;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] value;

    assign shamt = {operands.op_b[5] & ~operands.is_word, operands.op_b[4:0]};
    assign a_lo  = operands.op_a[31:0];
    assign sra_w = $signed(a_lo) >>> shamt[4:0];
    assign sra_d = $signed(operands.op_a) >>> shamt;

    always_comb begin
        case (operands.alu_op)
            rv_pipe_pkg::alu_sub:  alu_raw = operands.op_a - operands.op_b;
            rv_pipe_pkg::alu_cmp:  alu_raw = {63'd0, $signed(operands.op_a) < $signed(operands.op_b)};
            rv_pipe_pkg::alu_ucmp: alu_raw = {63'd0, operands.op_a < operands.op_b};
            rv_pipe_pkg::alu_and:  alu_raw = operands.op_a & operands.op_b;
            rv_pipe_pkg::alu_or:   alu_raw = operands.op_a | operands.op_b;
            rv_pipe_pkg::alu_xor:  alu_raw = operands.op_a ^ operands.op_b;
            rv_pipe_pkg::alu_sll:  alu_raw = operands.op_a << shamt;
            rv_pipe_pkg::alu_srl:  alu_raw = operands.is_word ? {32'd0, a_lo >> shamt[4:0]}
                                                              : operands.op_a >> shamt;
            rv_pipe_pkg::alu_sra:  alu_raw = operands.is_word ? {32'd0, sra_w} : sra_d;
            default:               alu_raw = operands.op_a + operands.op_b;
        endcase
    end

    assign alu_res = operands.is_word ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

    // funct3[2:1] picks the relation, funct3[0] inverts it
    assign eq  = operands.op_a == operands.rs2_value;
    assign lt  = $signed(operands.op_a) < $signed(operands.rs2_value);
    assign ltu = operands.op_a < operands.rs2_value;

    always_comb begin
        case (operands.funct3[2:1])
            2'b00:   cond = eq;
            2'b10:   cond = lt;
            default: cond = ltu;
        endcase
        cond = cond ^ operands.funct3[0];
    end

    assign taken = (operands.is_branch & cond) | operands.is_jal | operands.is_jalr;

    always_comb begin
        if (operands.is_jalr)
            target = (operands.op_a + operands.imm) & ~`RV_XLEN'd1;
        else if (operands.is_jal || operands.is_branch)
            target = operands.pc + operands.imm;
        else
            target = '0;
    end

    assign value = (operands.is_jal || operands.is_jalr) ? operands.pc + `RV_XLEN'd4 : alu_res;

    always_comb begin
        wb.enable = operands.valid && !operands.illegal && !operands.is_branch &&
                    operands.rd != 5'd0;
        wb.rd     = operands.rd;
        wb.value  = value;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
            retire       <= '0;
        end else begin
            retire_valid   <= operands.valid;
            retire.pc      <= operands.pc;
            retire.rd      <= operands.rd;
            retire.value   <= value;
            retire.taken   <= taken;
            retire.target  <= target;
            retire.illegal <= operands.illegal;
        end
    end

endmodule

`default_nettype wire

// ==== design/operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_consts.svh"

module operand_stage (
    input  logic                  clock,
    input  logic                  arst_n,
    input  rv_pipe_pkg::decoded_t decoded,
    input  rv_pipe_pkg::wb_t      wb,
    output rv_pipe_pkg::operand_t operands
);

    logic [`RV_XLEN-1:0]   rs1_rf;
    logic [`RV_XLEN-1:0]   rs2_rf;
    logic [`RV_XLEN-1:0]   rs1_value;
    logic [`RV_XLEN-1:0]   rs2_value;
    rv_pipe_pkg::operand_t op_next;

    reg_file reg_file_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .rs1       (decoded.rs1),
        .rs2       (decoded.rs2),
        .rs1_value (rs1_rf),
        .rs2_value (rs2_rf),
        .wb        (wb)
    );

    // The instruction in execute writes at the coming edge, so take its result now
    always_comb begin
        rs1_value = rs1_rf;
        rs2_value = rs2_rf;
        if (wb.enable && decoded.rs1 != 5'd0 && wb.rd == decoded.rs1)
            rs1_value = wb.value;
        if (wb.enable && decoded.rs2 != 5'd0 && wb.rd == decoded.rs2)
            rs2_value = wb.value;
    end

    always_comb begin
        op_next.valid     = decoded.valid;
        op_next.pc        = decoded.pc;
        op_next.rd        = decoded.rd;
        op_next.op_a      = decoded.use_pc ? decoded.pc : rs1_value;
        op_next.op_b      = decoded.use_imm ? decoded.imm : rs2_value;
        op_next.rs2_value = rs2_value;
        op_next.imm       = decoded.imm;
        op_next.alu_op    = decoded.alu_op;
        op_next.funct3    = decoded.funct3;
        op_next.is_jal    = decoded.is_jal;
        op_next.is_jalr   = decoded.is_jalr;
        op_next.is_branch = decoded.is_branch;
        op_next.is_word   = decoded.is_word;
        op_next.illegal   = decoded.illegal;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            operands <= '0;
        else
            operands <= op_next;
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_consts.svh"

module reg_file (
    input  logic                clock,
    input  logic                arst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rs1_value,
    output logic [`RV_XLEN-1:0] rs2_value,
    input  rv_pipe_pkg::wb_t    wb
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];   // x0 has no storage

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end else if (wb.enable && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_consts.svh"

module inst_decoder (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 inst_valid,
    input  logic [31:0]          inst,
    input  logic [`RV_XLEN-1:0]  pc,
    output rv_pipe_pkg::decoded_t decoded
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [6:0]            shift_f7;
    logic [`RV_XLEN-1:0]   imm;
    logic                  legal;
    logic                  is_word;
    rv_pipe_pkg::itype_e   fmt;
    rv_pipe_pkg::alu_op_e  alu_op;
    rv_pipe_pkg::decoded_t dec_next;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign is_word = opcode == `OPC_OP_32 || opcode == `OPC_OP_IMM_32;
    // RV64 shifts keep shamt[5] in bit 25, word shifts do not
    assign shift_f7 = (is_word || opcode == `OPC_OP) ? funct7 : {funct7[6:1], 1'b0};

    always_comb begin
        case (opcode)
            `OPC_LUI, `OPC_AUIPC:                      fmt = rv_pipe_pkg::fmt_u;
            `OPC_JAL:                                  fmt = rv_pipe_pkg::fmt_j;
            `OPC_JALR, `OPC_OP_IMM, `OPC_OP_IMM_32:    fmt = rv_pipe_pkg::fmt_i;
            `OPC_BRANCH:                               fmt = rv_pipe_pkg::fmt_b;
            `OPC_OP, `OPC_OP_32:                       fmt = rv_pipe_pkg::fmt_r;
            default:                                   fmt = rv_pipe_pkg::fmt_none;
        endcase
    end

    always_comb begin
        case (fmt)
            rv_pipe_pkg::fmt_i: imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
            rv_pipe_pkg::fmt_b: imm = {{(`RV_XLEN-12){inst[31]}}, inst[7], inst[30:25],
                                       inst[11:8], 1'b0};
            rv_pipe_pkg::fmt_u: imm = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            rv_pipe_pkg::fmt_j: imm = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20],
                                       inst[30:21], 1'b0};
            default:            imm = '0;
        endcase
    end

    always_comb begin
        legal  = 1'b0;
        alu_op = rv_pipe_pkg::alu_add;   // LUI, AUIPC and jumps add
        case (opcode)
            `OPC_LUI, `OPC_AUIPC, `OPC_JAL: legal = 1'b1;
            `OPC_JALR:                      legal = funct3 == `F3_JALR;
            `OPC_BRANCH: begin
                legal = funct3 != 3'b010 && funct3 != 3'b011;
                case (funct3)
                    `F3_BEQ, `F3_BNE:   alu_op = rv_pipe_pkg::alu_sub;
                    `F3_BLT, `F3_BGE:   alu_op = rv_pipe_pkg::alu_cmp;
                    `F3_BLTU, `F3_BGEU: alu_op = rv_pipe_pkg::alu_ucmp;
                    default:            alu_op = rv_pipe_pkg::alu_add;
                endcase
            end
            `OPC_OP_IMM, `OPC_OP_IMM_32, `OPC_OP, `OPC_OP_32: begin
                case (funct3)
                    `F3_ADD: begin
                        legal = fmt == rv_pipe_pkg::fmt_i || funct7 == `F7_BASE ||
                                funct7 == `F7_ALT;
                        if (fmt == rv_pipe_pkg::fmt_r && funct7 == `F7_ALT)
                            alu_op = rv_pipe_pkg::alu_sub;
                    end
                    `F3_SLL: begin
                        legal  = shift_f7 == `F7_BASE;
                        alu_op = rv_pipe_pkg::alu_sll;
                    end
                    `F3_SRL: begin
                        legal = shift_f7 == `F7_BASE || shift_f7 == `F7_ALT;
                        if (shift_f7 == `F7_ALT)
                            alu_op = rv_pipe_pkg::alu_sra;
                        else
                            alu_op = rv_pipe_pkg::alu_srl;
                    end
                    default: begin   // Compare and logic have no word forms
                        legal = !is_word && (fmt == rv_pipe_pkg::fmt_i || funct7 == `F7_BASE);
                        case (funct3)
                            `F3_SLT:  alu_op = rv_pipe_pkg::alu_cmp;
                            `F3_SLTU: alu_op = rv_pipe_pkg::alu_ucmp;
                            `F3_XOR:  alu_op = rv_pipe_pkg::alu_xor;
                            `F3_OR:   alu_op = rv_pipe_pkg::alu_or;
                            default:  alu_op = rv_pipe_pkg::alu_and;
                        endcase
                    end
                endcase
                if (fmt == rv_pipe_pkg::fmt_r && funct7 == `F7_MEXT)
                    legal = 1'b0;   // No multiply or divide unit
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        dec_next.valid     = inst_valid;
        dec_next.pc        = pc;
        dec_next.rd        = (legal && fmt != rv_pipe_pkg::fmt_b) ? inst[11:7] : 5'd0;
        dec_next.rs1       = (legal && fmt inside {rv_pipe_pkg::fmt_r, rv_pipe_pkg::fmt_i,
                                                   rv_pipe_pkg::fmt_b}) ? inst[19:15] : 5'd0;
        dec_next.rs2       = (legal && fmt inside {rv_pipe_pkg::fmt_r, rv_pipe_pkg::fmt_b})
                             ? inst[24:20] : 5'd0;
        dec_next.imm       = legal ? imm : '0;
        dec_next.alu_op    = legal ? alu_op : rv_pipe_pkg::alu_add;
        dec_next.funct3    = funct3;
        dec_next.use_pc    = legal && (opcode == `OPC_AUIPC || opcode == `OPC_JAL);
        dec_next.use_imm   = legal && fmt != rv_pipe_pkg::fmt_r && fmt != rv_pipe_pkg::fmt_b;
        dec_next.is_jal    = legal && opcode == `OPC_JAL;
        dec_next.is_jalr   = legal && opcode == `OPC_JALR;
        dec_next.is_branch = legal && opcode == `OPC_BRANCH;
        dec_next.is_word   = legal && is_word;
        dec_next.illegal   = !legal;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            decoded <= '0;
        else
            decoded <= dec_next;
    end

endmodule

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none
`include "rv_pipe_consts.svh"

package rv_pipe_pkg;

    typedef enum logic [2:0] {
        fmt_none,
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } itype_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_cmp,     // Signed set-less-than
        alu_ucmp,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             alu_op;
        logic [2:0]          funct3;
        logic                use_pc;    // op_a from pc
        logic                use_imm;   // op_b from immediate
        logic                is_jal;
        logic                is_jalr;
        logic                is_branch;
        logic                is_word;
        logic                illegal;
    } decoded_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] op_a;
        logic [`RV_XLEN-1:0] op_b;
        logic [`RV_XLEN-1:0] rs2_value;
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             alu_op;
        logic [2:0]          funct3;
        logic                is_jal;
        logic                is_jalr;
        logic                is_branch;
        logic                is_word;
        logic                illegal;
    } operand_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] value;
        logic                taken;
        logic [`RV_XLEN-1:0] target;
        logic                illegal;
    } retire_t;

    typedef struct packed {
        logic                enable;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] value;
    } wb_t;

endpackage

`default_nettype wire

// ==== design/rv_pipe_consts.svh ====
`ifndef RV_PIPE_CONSTS_SVH
`define RV_PIPE_CONSTS_SVH

`define RV_XLEN  64
`define RV_NREGS 32

// Major opcodes, inst[6:0]
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP_32     7'b0111011

`define F3_JALR 3'b000

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SRL  3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000
`define F7_MEXT 7'b0000001

`endif
